// ==== dv/mem_system_checker.sv ====
`default_nettype none

module mem_system_checker (
	input logic clk,
	input logic arst_n,
	input logic done,
	input logic stall,
	input logic err
);

	int unsigned fail_count = 0; // Read by the testbench at the end

	done_stall_excl: assert property (@(posedge clk) disable iff (!arst_n) !(done && stall))
		else begin
			$error("done and stall are high in the same cycle");
			fail_count++;
		end

	err_low: assert property (@(posedge clk) disable iff (!arst_n) !err)
		else begin
			$error("err went high");
			fail_count++;
		end

	// Clean miss or miss with write-back
	miss_length: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(stall) |-> (##8 done) or (##12 done))
		else begin
			$error("done did not follow a stall 8 or 12 cycles later");
			fail_count++;
		end

	reset_quiet: assert property (@(posedge clk) !arst_n |-> !done && !stall && !err)
		else begin
			$error("done, stall or err high during reset");
			fail_count++;
		end

endmodule

bind mem_system mem_system_checker checker_i (
	.clk(clk),
	.arst_n(arst_n),
	.done(done),
	.stall(stall),
	.err(err)
);

`default_nettype wire

// ==== dv/mem_system_tb.sv ====
`default_nettype none

module mem_system_tb;

	localparam int TIMEOUT_CYCLES = 40;
	localparam int MISS_CYCLES = 8;
	localparam int DIRTY_MISS_CYCLES = 12;
	localparam int RANDOM_OPS = 150;

	logic clk;
	logic arst_n;
	logic [15:0] addr;
	logic [15:0] data_in;
	logic rd;
	logic wr;
	logic [15:0] data_out;
	logic done;
	logic stall;
	logic cache_hit;
	logic err;

	logic [15:0] shadow [logic [15:0]]; // Last value written per address
	logic [31:0] rng_state;
	int checks;
	int errors;
	int timeouts;

	tb_clock_gen #(.PERIOD(40)) clock_i (.clk(clk));

	mem_system #(
		.MEM_WORDS(32768)
	) mem_system_i (
		.clk(clk), .arst_n(arst_n), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
		.data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Tag 15:11, index 10:3, word 2:1, byte bit 0
	function automatic logic [15:0] make_addr(input int tag, input int index, input int word);
		return {5'(tag), 8'(index), 2'(word), 1'b0};
	endfunction

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("[FAIL] %0t: %s", $time, msg);
		end
	endtask

	task automatic finish_run();
		int asserts;
		asserts = mem_system_i.checker_i.fail_count;
		$display("Checks: %0d, data errors: %0d, assertion failures: %0d, timeouts: %0d",
			checks, errors, asserts, timeouts);
		if (errors == 0 && asserts == 0 && timeouts == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	// One CPU access, with optional stray strobes while the miss stalls
	task automatic cpu_access(input logic is_wr, input logic [15:0] a, input logic [15:0] d,
			input int stray_at, input logic [15:0] stray_addr,
			output logic hit, output int cycles);
		int n;
		@(posedge clk);
		#5;
		addr = a;
		data_in = d;
		wr = is_wr;
		rd = ~is_wr;
		@(negedge clk);
		hit = done;
		n = 0;
		if (hit) begin
			check(cache_hit === 1'b1 && stall === 1'b0, $sformatf("hit at %h lacks cache_hit", a));
			if (!is_wr) begin
				check(data_out === shadow[a], $sformatf("read hit %h returned %h, expected %h",
					a, data_out, shadow[a]));
			end
			@(posedge clk);
			#5;
			rd = 1'b0;
			wr = 1'b0;
		end else begin
			check(stall === 1'b1, $sformatf("miss at %h without stall", a));
			do begin
				@(posedge clk);
				#5;
				n++;
				rd = 1'b0;
				wr = 1'b0;
				if (stray_at > 0 && n == stray_at) begin
					addr = stray_addr;
					data_in = ~d;
					wr = 1'b1;
				end else if (stray_at > 0 && n == stray_at + 2) begin
					addr = stray_addr;
					rd = 1'b1;
				end
				@(negedge clk);
			end while (done !== 1'b1 && n < TIMEOUT_CYCLES);
			if (done !== 1'b1) begin
				$display("Timeout: no done within %0d cycles of the access to %h", TIMEOUT_CYCLES, a);
				timeouts++;
				finish_run();
			end else if (!is_wr) begin
				check(data_out === shadow[a], $sformatf("read miss %h returned %h, expected %h",
					a, data_out, shadow[a]));
			end
		end
		if (is_wr) begin
			shadow[a] = d;
		end
		cycles = n;
	endtask

	initial begin
		logic hit;
		logic is_wr_op;
		int cycles;
		logic [15:0] a;
		logic [15:0] line_a;
		logic [15:0] evict_a [3];
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		data_in = '0;
		arst_n = 1'b0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		rng_state = 32'haef819a9;
		repeat (8) @(posedge clk);
		#5;
		arst_n = 1'b1;

		line_a = make_addr(1, 'h10, 0); // Cold write miss, then read hit
		cpu_access(1'b1, line_a, 16'h1234, 0, '0, hit, cycles);
		check(!hit && cycles == MISS_CYCLES, $sformatf("cold miss took %0d cycles", cycles));
		cpu_access(1'b0, line_a, '0, 0, '0, hit, cycles);
		check(hit, "read after fill did not hit");

		for (int w = 1; w < 4; w++) begin
			cpu_access(1'b1, make_addr(1, 'h10, w), 16'h1100 + 16'(w), 0, '0, hit, cycles);
			check(hit, $sformatf("write to word %0d of filled line missed", w));
		end
		for (int w = 1; w < 4; w++) begin
			cpu_access(1'b0, make_addr(1, 'h10, w), '0, 0, '0, hit, cycles);
			check(hit, $sformatf("read of word %0d of filled line missed", w));
		end

		// Third tag in one set evicts dirty way 0
		for (int t = 0; t < 3; t++) begin
			evict_a[t] = make_addr(t + 1, 'h20, t);
			cpu_access(1'b1, evict_a[t], 16'h2000 + 16'(t), 0, '0, hit, cycles);
			check(!hit && cycles == (t == 2 ? DIRTY_MISS_CYCLES : MISS_CYCLES),
				$sformatf("write miss %0d in shared set took %0d cycles", t, cycles));
		end
		for (int t = 0; t < 3; t++) begin
			cpu_access(1'b0, evict_a[t], '0, 0, '0, hit, cycles);
		end

		for (int i = 0; i < RANDOM_OPS; i++) begin
			rng_state = lcg_next(rng_state);
			a = make_addr(int'(rng_state[17:16]), 'h80 + int'(rng_state[19:18]),
				int'(rng_state[21:20]));
			is_wr_op = rng_state[24] || !shadow.exists(a); // Never read unwritten words
			rng_state = lcg_next(rng_state);
			cpu_access(is_wr_op, a, rng_state[31:16], 0, '0, hit, cycles);
		end

		a = make_addr(5, 'h40, 1); // Stray strobes to line_a during this miss
		cpu_access(1'b1, a, 16'h5a5a, 2, line_a, hit, cycles);
		check(!hit, "write to fresh line in set 0x40 hit");
		cpu_access(1'b0, line_a, '0, 0, '0, hit, cycles);
		cpu_access(1'b0, a, '0, 0, '0, hit, cycles);

		finish_run();
	end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/mem_system_pkg.sv
verilog/cache_way.sv
verilog/banked_memory.sv
verilog/cache_controller.sv
verilog/mem_system.sv
dv/tb_clock_gen.sv
dv/mem_system_checker.sv
dv/mem_system_tb.sv

// ==== verilog/banked_memory.sv ====
`default_nettype none

module banked_memory #(
	parameter int MEM_WORDS = 32768
) (
	input  logic clk,
	input  mem_system_pkg::mem_req_t req,
	output logic [15:0] rd_data
);
	import mem_system_pkg::*;

	localparam int BANK_DEPTH = MEM_WORDS / WORDS_PER_LINE;
	localparam int ROW_W = $clog2(BANK_DEPTH);

	logic [ROW_W-1:0] row;
	logic [15:0] bank_rd [WORDS_PER_LINE];
	logic [15:0] rd_pipe [MEM_LATENCY];

	assign row = req.addr.mem.row[ROW_W-1:0];

	genvar b;
	generate
		for (b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
			logic [15:0] mem [BANK_DEPTH];

			always_ff @(posedge clk) begin
				if (req.wr && req.addr.mem.bank == 2'(b)) begin
					mem[row] <= req.data;
				end
			end

			assign bank_rd[b] = mem[row]; // Async array read
		end
	endgenerate

	// Two reads may be in flight, one per stage
	always_ff @(posedge clk) begin
		if (req.rd) begin
			rd_pipe[0] <= bank_rd[req.addr.mem.bank];
		end
		for (int i = 1; i < MEM_LATENCY; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	assign rd_data = rd_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

// ==== verilog/cache_controller.sv ====
`default_nettype none

module cache_controller (
	input  logic clk,
	input  logic arst_n,
	input  logic [15:0] addr,
	input  logic [15:0] data_in,
	input  logic rd,
	input  logic wr,
	input  mem_system_pkg::way_status_t status0,
	input  mem_system_pkg::way_status_t status1,
	output mem_system_pkg::addr_u req_addr,
	output logic [15:0] req_data,
	output mem_system_pkg::cache_ctrl_t ctrl,
	output mem_system_pkg::mem_req_t mem_req,
	output logic fill_way,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err
);
	import mem_system_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE = 4'd0,
		S_ENABLE,
		S_RD0, S_RD1, S_RD2, S_RD3, // Write-back reads of the victim
		S_REQ0, S_REQ1,
		S_REQ2_WR0, S_REQ3_WR1, // Requests overlap fill writes
		S_WR2, S_WR3,
		S_DONE
	} state_t;

	state_t state, state_nxt;
	addr_u addr_q;
	logic [15:0] data_q;
	logic wr_q;
	logic victim, victim_nxt;
	logic way_sel, way_sel_nxt;
	logic access;
	logic hit_any;
	logic sel_dirty;
	logic [1:0] word;

	assign access = rd ^ wr;
	assign hit_any = (status0.hit & status0.valid) | (status1.hit & status1.valid);
	assign req_addr = (state == S_IDLE) ? addr_u'(addr) : addr_q;
	assign req_data = (state == S_IDLE) ? data_in : data_q;
	assign fill_way = way_sel;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			victim <= 1'b0;
			way_sel <= 1'b0;
			wr_q <= 1'b0;
		end else begin
			state <= state_nxt;
			victim <= victim_nxt;
			way_sel <= way_sel_nxt;
			if (state == S_IDLE) begin
				wr_q <= wr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE) begin
			addr_q <= addr;
			data_q <= data_in;
		end
	end

	always_comb begin
		state_nxt = state;
		victim_nxt = victim;
		way_sel_nxt = way_sel;
		sel_dirty = 1'b0;
		word = '0;
		ctrl = '0;
		ctrl.enable = way_sel ? 2'b10 : 2'b01;
		ctrl.offset = addr_q.cache.offset;
		mem_req.addr = addr_q;
		mem_req.data = data_q; // Replaced by way data on write-back
		mem_req.wr = 1'b0;
		mem_req.rd = 1'b0;
		done = 1'b0;
		stall = 1'b1;
		cache_hit = 1'b0;
		err = 1'b0;

		case (state)
			S_IDLE: begin
				ctrl.enable = access ? 2'b11 : 2'b00; // Look up both ways
				ctrl.offset = req_addr.cache.offset;
				ctrl.comp = 1'b1;
				ctrl.write = wr & ~rd;
				done = access & hit_any;
				cache_hit = access & hit_any;
				stall = access & ~hit_any;
				err = rd & wr;
				if (access && !hit_any) begin
					state_nxt = S_ENABLE;
				end
			end
			S_ENABLE: begin
				ctrl.enable = 2'b00;
				if (!status0.valid) begin
					way_sel_nxt = 1'b0;
				end else if (!status1.valid) begin
					way_sel_nxt = 1'b1;
				end else begin
					way_sel_nxt = victim; // Both valid, replace victim
					victim_nxt = ~victim;
				end
				sel_dirty = way_sel_nxt ? (status1.valid & status1.dirty)
					: (status0.valid & status0.dirty);
				state_nxt = sel_dirty ? S_RD0 : S_REQ0;
			end
			S_RD0, S_RD1, S_RD2, S_RD3: begin
				word = 2'(state - S_RD0);
				ctrl.offset = {word, 1'b0};
				ctrl.tag_src = 1'b1;
				mem_req.addr.cache.offset = {word, 1'b0};
				mem_req.wr = 1'b1;
				state_nxt = state_t'(state + 4'd1);
			end
			S_REQ0, S_REQ1: begin
				word = 2'(state - S_REQ0);
				mem_req.addr.cache.offset = {word, 1'b0};
				mem_req.rd = 1'b1;
				state_nxt = state_t'(state + 4'd1);
			end
			S_REQ2_WR0, S_REQ3_WR1: begin
				word = 2'(state - S_REQ0);
				mem_req.addr.cache.offset = {word, 1'b0};
				mem_req.rd = 1'b1;
				ctrl.offset = {2'(state - S_REQ2_WR0), 1'b0};
				ctrl.write = 1'b1;
				ctrl.data_src = 1'b1;
				state_nxt = state_t'(state + 4'd1);
			end
			S_WR2, S_WR3: begin
				word = 2'(state - S_REQ2_WR0);
				ctrl.offset = {word, 1'b0};
				ctrl.write = 1'b1;
				ctrl.data_src = 1'b1;
				state_nxt = state_t'(state + 4'd1);
			end
			S_DONE: begin
				ctrl.comp = 1'b1; // Replay the CPU access on the filled line
				ctrl.write = wr_q;
				done = 1'b1;
				stall = 1'b0;
				state_nxt = S_IDLE;
			end
			default: begin
				err = 1'b1;
				state_nxt = S_IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/cache_way.sv ====
`default_nettype none

module cache_way (
	input  logic clk,
	input  logic arst_n,
	input  mem_system_pkg::addr_u addr,
	input  mem_system_pkg::cache_ctrl_t ctrl,
	input  logic en,
	input  logic [15:0] fill_data,
	input  logic [15:0] wr_data,
	output mem_system_pkg::way_status_t status,
	output logic [15:0] rd_data,
	output logic [4:0] tag
);
	import mem_system_pkg::*;

	localparam int LINES = 2 ** INDEX_W;
	localparam int WORD_W = $clog2(WORDS_PER_LINE);

	logic [4:0] tag_mem [LINES];
	logic [15:0] data_mem [LINES][WORDS_PER_LINE];
	logic [LINES-1:0] valid;
	logic [LINES-1:0] dirty;

	logic [INDEX_W-1:0] idx;
	logic [WORD_W-1:0] word;
	logic tag_match;
	logic wr_cmp;
	logic wr_fill;
	logic last_word;

	assign idx = addr.cache.index;
	assign word = ctrl.offset[WORD_W:1]; // Drop byte bit
	assign tag_match = tag_mem[idx] == addr.cache.tag;

	// CPU write lands only on a valid hit
	assign wr_cmp = en & ctrl.write & ctrl.comp & tag_match & valid[idx];
	assign wr_fill = en & ctrl.write & ~ctrl.comp;
	assign last_word = word == WORD_W'(WORDS_PER_LINE - 1);

	assign status = '{hit: tag_match, valid: valid[idx], dirty: dirty[idx]};
	assign rd_data = data_mem[idx][word];
	assign tag = tag_mem[idx]; // Write-back address tag

	always_ff @(posedge clk) begin
		if (wr_cmp || wr_fill) begin
			data_mem[idx][word] <= ctrl.data_src ? fill_data : wr_data;
		end
		if (wr_fill && last_word) begin
			tag_mem[idx] <= addr.cache.tag;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
			dirty <= '0;
		end else begin
			if (wr_cmp) begin
				dirty[idx] <= 1'b1;
			end
			if (wr_fill) begin
				dirty[idx] <= 1'b0; // Fresh line from memory
				if (last_word) begin
					valid[idx] <= 1'b1; // Line complete
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mem_system.sv ====
`default_nettype none

module mem_system #(
	parameter int MEM_WORDS = 32768
) (
	input  logic clk,
	input  logic arst_n,
	input  logic [15:0] addr,
	input  logic [15:0] data_in,
	input  logic rd,
	input  logic wr,
	output logic [15:0] data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err
);
	import mem_system_pkg::*;

	addr_u req_addr;
	logic [15:0] req_data;
	cache_ctrl_t ctrl;
	mem_req_t ctrl_mem_req;
	mem_req_t mem_req;
	logic fill_way;
	way_status_t status0, status1;
	logic [15:0] way_rd0, way_rd1;
	logic [4:0] tag0, tag1;
	logic [15:0] mem_rd_data;
	logic out_way;

	cache_controller controller_i (
		.clk(clk), .arst_n(arst_n),
		.addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
		.status0(status0), .status1(status1),
		.req_addr(req_addr), .req_data(req_data), .ctrl(ctrl),
		.mem_req(ctrl_mem_req), .fill_way(fill_way),
		.done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
	);

	cache_way way0_i (
		.clk(clk), .arst_n(arst_n), .addr(req_addr), .ctrl(ctrl), .en(ctrl.enable[0]),
		.fill_data(mem_rd_data), .wr_data(req_data),
		.status(status0), .rd_data(way_rd0), .tag(tag0)
	);

	cache_way way1_i (
		.clk(clk), .arst_n(arst_n), .addr(req_addr), .ctrl(ctrl), .en(ctrl.enable[1]),
		.fill_data(mem_rd_data), .wr_data(req_data),
		.status(status1), .rd_data(way_rd1), .tag(tag1)
	);

	// Hitting way on a hit, else the way just filled
	assign out_way = cache_hit ? (status1.hit & status1.valid) : fill_way;
	assign data_out = out_way ? way_rd1 : way_rd0;

	always_comb begin
		mem_req = ctrl_mem_req;
		if (ctrl.tag_src) begin // Victim line goes back to its own address
			mem_req.addr.cache.tag = fill_way ? tag1 : tag0;
			mem_req.data = fill_way ? way_rd1 : way_rd0;
		end
	end

	banked_memory #(
		.MEM_WORDS(MEM_WORDS)
	) memory_i (
		.clk(clk),
		.req(mem_req),
		.rd_data(mem_rd_data)
	);

endmodule

`default_nettype wire

// ==== verilog/mem_system_pkg.sv ====
`default_nettype none

package mem_system_pkg;

	localparam int INDEX_W = 8; // 256 sets
	localparam int WORDS_PER_LINE = 4;
	localparam int MEM_LATENCY = 2; // Cycles from rd to data

	typedef struct packed {
		logic [4:0] tag;
		logic [INDEX_W-1:0] index;
		logic [2:0] offset; // Byte offset in line
	} addr_cache_t;

	// Consecutive words of a line fall into consecutive banks
	typedef struct packed {
		logic [12:0] row;
		logic [1:0] bank;
		logic byte_sel;
	} addr_mem_t;

	typedef union packed {
		addr_cache_t cache;
		addr_mem_t mem;
	} addr_u;

	typedef struct packed {
		logic hit; // Tag match only
		logic valid;
		logic dirty;
	} way_status_t;

	typedef struct packed {
		logic [1:0] enable; // One bit per way
		logic [2:0] offset;
		logic comp; // Compare mode, CPU access
		logic write;
		logic data_src; // 1 = fill from memory
		logic tag_src; // 1 = stored tag for write-back
	} cache_ctrl_t;

	typedef struct packed {
		addr_u addr;
		logic [15:0] data;
		logic wr;
		logic rd;
	} mem_req_t;

endpackage

`default_nettype wire
